//--- src/gb_cart_pkg.sv
/*
 * cartridge core shared definitions
 * bus widths, bank register types, controller kind codes
 * and the header byte locations inside a downloaded image
 */
package gb_cart_pkg;

	// ----------------------------------------------------------
	// bus and register types
	// ----------------------------------------------------------
	typedef logic [7:0]  byte_t;      // cpu data byte
	typedef logic [15:0] cart_addr_t; // cpu side cartridge address
	typedef logic [15:0] dl_word_t;   // download word, odd byte on top
	typedef logic [8:0]  rom_bank_t;  // rom bank and rom bank mask
	typedef logic [3:0]  ram_bank_t;  // ram bank and ram bank mask
	typedef logic [2:0]  mbc_kind_t;  // decoded controller kind

	// ----------------------------------------------------------
	// controller kinds
	// ----------------------------------------------------------
	localparam mbc_kind_t MBC_NONE = 3'd0; // plain 32k rom
	localparam mbc_kind_t MBC_1    = 3'd1;
	localparam mbc_kind_t MBC_2    = 3'd2; // 512 x 4 bit internal ram
	localparam mbc_kind_t MBC_3    = 3'd3; // has rtc register select
	localparam mbc_kind_t MBC_5    = 3'd5; // 9 bit rom bank

	// header words as seen on the download byte address
	localparam logic [22:0] HDR_TYPE_ADDR = 23'h000146; // type byte in high half
	localparam logic [22:0] HDR_SIZE_ADDR = 23'h000148; // ram size high, rom size low

	// low nibble written to 0x0000-0x1fff that opens cart ram
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

endpackage

//--- src/gb_cart_ifs.sv
/*
 * internal buses of the cartridge core
 * cpu cartridge bus, decoded header info and the live bank state
 */
`timescale 1ns/100ps

// cpu side cartridge bus
interface cart_bus_if import gb_cart_pkg::*; ();
	cart_addr_t addr;  // cpu address
	logic       rd;    // read level
	logic       wr;    // one cycle write strobe
	byte_t      wdata; // cpu write byte

	// bank register block only looks at writes
	modport ctrl (
		input addr,
		input wr,
		input wdata
	);

	// mapper needs the read level and the write strobe for ram
	modport map (
		input addr,
		input rd,
		input wr
	);
endinterface

// header fields decoded after download
interface cart_info_if import gb_cart_pkg::*; ();
	mbc_kind_t mbc_kind;   // controller kind
	rom_bank_t rom_mask;   // rom bank mirror mask
	ram_bank_t ram_mask;   // ram bank mirror mask
	logic      cart_ready; // an image has been loaded

	modport src (
		output mbc_kind,
		output rom_mask,
		output ram_mask,
		output cart_ready
	);

	modport ctrl (input mbc_kind); // register decode depends on kind only

	modport map (
		input mbc_kind,
		input rom_mask,
		input ram_mask,
		input cart_ready
	);
endinterface

// bank register state for the mapper
interface bank_if import gb_cart_pkg::*; ();
	rom_bank_t rom_bank;   // raw rom bank, unmasked
	ram_bank_t ram_bank;   // raw ram bank, unmasked
	logic      mbc1_mode;  // mbc1 banking mode
	logic      rtc_mode;   // mbc3 rtc selected at a000
	logic      ram_enable;

	modport src (output rom_bank, output ram_bank, output mbc1_mode,
		output rtc_mode, output ram_enable);
	modport map (input rom_bank, input ram_bank, input mbc1_mode,
		input rtc_mode, input ram_enable);
endinterface

//--- src/cart_header.sv
/*
 * cartridge header capture
 * grabs type and size bytes while the image streams in and
 * decodes controller kind and bank mirror masks
 */
`timescale 1ns/100ps

module cart_header import gb_cart_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_cart,  // cartridge download active
	input  logic        dl_wr,    // one cycle download strobe
	input  logic [22:0] dl_addr,  // download byte address
	input  dl_word_t    dl_data,
	cart_info_if.src    info
);

	byte_t type_q;     // 0x147 controller type code
	byte_t rom_size_q; // 0x148 rom size code
	byte_t ram_size_q; // 0x149 ram size code
	logic  ready_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_q     <= '0;
			rom_size_q <= '0;
			ram_size_q <= '0;
			ready_q    <= 1'b0;
		end else if (dl_cart && dl_wr) begin
			ready_q <= 1'b1; // any download word marks a loaded cart
			if (dl_addr == HDR_TYPE_ADDR)
				type_q <= dl_data[15:8];
			if (dl_addr == HDR_SIZE_ADDR)
				{ram_size_q, rom_size_q} <= dl_data;
		end
	end

	// type code ranges from the cartridge header spec
	always_comb begin
		case (type_q) inside
			[8'd1:8'd3]:   info.mbc_kind = MBC_1;
			[8'd5:8'd6]:   info.mbc_kind = MBC_2;
			[8'd15:8'd19]: info.mbc_kind = MBC_3;
			[8'd25:8'd30]: info.mbc_kind = MBC_5;
			default:       info.mbc_kind = MBC_NONE;
		endcase
	end

	// rom of 2^(code+1) banks of 16k, odd sizes fall back to 128 banks
	assign info.rom_mask = (rom_size_q >= 8'd1 && rom_size_q <= 8'd8) ?
		rom_bank_t'((10'd2 << rom_size_q[3:0]) - 10'd1) : 9'h07F;

	assign info.ram_mask = (ram_size_q <= 8'd2) ? 4'h0 : // at most one 8k bank
		(ram_size_q == 8'd3) ? 4'h3 : 4'hF;             // 32k or 128k

	assign info.cart_ready = ready_q;

	// header fields only ever move during a cartridge download
	a_hdr_quiet: assert property (@(posedge clk_sys) disable iff (reset)
		!dl_cart |=> $stable(type_q) && $stable(rom_size_q) &&
			$stable(ram_size_q) && $stable(ready_q))
		else $error("header changed outside a cartridge download");

endmodule

//--- src/mbc_regs.sv
/*
 * bank controller registers
 * cpu writes into 0x0000-0x7fff land here for mbc1, mbc2, mbc3 and mbc5
 */
`timescale 1ns/100ps

module mbc_regs import gb_cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      dl_cart,  // registers parked at defaults while loading
	cart_bus_if.ctrl  bus,
	cart_info_if.ctrl info,
	bank_if.src       bank
);

	rom_bank_t rom_bank;
	ram_bank_t ram_bank;
	logic      mbc1_mode;
	logic      rtc_mode;
	logic      ram_enable;

	logic is_mbc1, is_mbc3, is_mbc5;

	assign is_mbc1 = (info.mbc_kind == MBC_1);
	assign is_mbc3 = (info.mbc_kind == MBC_3);
	assign is_mbc5 = (info.mbc_kind == MBC_5);

	// ----------------------------------------------------------
	// write decode on address bits 15..13
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_cart) begin
			rom_bank   <= 9'd1; // bank 1 sits at 0x4000 out of reset
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
			ram_enable <= 1'b0;
		end else if (bus.wr) begin
			case (bus.addr[15:13])
				3'b000: ram_enable <= (bus.wdata[3:0] == RAM_ENABLE_KEY);
				3'b001: begin
					if (is_mbc5) begin
						if (bus.addr[12])
							rom_bank[8] <= bus.wdata[0];   // 0x3xxx high bit
						else
							rom_bank[7:0] <= bus.wdata;    // 0x2xxx low byte
					end else if (bus.wdata[6:0] == 7'd0) begin
						rom_bank <= 9'd1;                  // bank 0 not reachable here
					end else begin
						rom_bank <= {2'b00, bus.wdata[6:0]};
					end
				end
				3'b010: begin
					if (is_mbc3) begin
						rtc_mode <= bus.wdata[3]; // 0x08-0x0c pick an rtc register
						if (!bus.wdata[3])
							ram_bank <= {2'b00, bus.wdata[1:0]};
					end else if (is_mbc5) begin
						ram_bank <= bus.wdata[3:0];    // up to 16 banks
					end else begin
						ram_bank <= {2'b00, bus.wdata[1:0]};
					end
				end
				3'b011: if (is_mbc1) mbc1_mode <= bus.wdata[0];
				default: ; // ram and upper space, not a register write
			endcase
		end
	end

	assign bank.rom_bank   = rom_bank;
	assign bank.ram_bank   = ram_bank;
	assign bank.mbc1_mode  = mbc1_mode;
	assign bank.rtc_mode   = rtc_mode;
	assign bank.ram_enable = ram_enable;

	// older controllers never map bank 0 into the switchable window
	a_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		bus.wr && bus.addr[15:13] == 3'b001 && !is_mbc5 |=> rom_bank[6:0] != 7'd0)
		else $error("7 bit rom bank became zero after a bank write");

endmodule

//--- src/cart_mapper.sv
/*
 * cartridge address mapper
 * banked rom word address, banked cart ram address and the
 * registered choice of the byte returned to the cpu
 */
`timescale 1ns/100ps

module cart_mapper import gb_cart_pkg::*; #(
	parameter int ROM_WORD_W = 22,
	parameter int RAM_ADDR_W = 17
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_cart,
	input  logic                  dl_wr,
	input  logic [22:0]           dl_addr,
	cart_bus_if.map               bus,
	cart_info_if.map              info,
	bank_if.map                   bank,
	input  dl_word_t              rom_q,    // answers rom_addr in the same cycle
	output logic [ROM_WORD_W-1:0] rom_addr,
	output logic                  rom_we,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_we,
	input  byte_t                 ram_q,    // one cycle after ram_addr
	output byte_t                 cart_rdata
);

	localparam logic [1:0] SEL_ZERO = 2'd0, SEL_FF = 2'd1, SEL_ROM = 2'd2, SEL_RAM = 2'd3;

	logic [6:0] mbc1_bank;
	rom_bank_t  bank_sel;  // masked bank for the 0x4000 window
	ram_bank_t  ram_sel;   // masked ram bank
	logic [9:0] rom_index; // 8k half index
	logic       is_ram;
	logic [1:0] sel_q;
	logic       nib_q;     // mbc2 4 bit ram
	byte_t      rom_byte_q;

	// ----------------------------------------------------------
	// rom side
	// ----------------------------------------------------------
	always_comb begin
		mbc1_bank = {bank.mbc1_mode ? 2'b00 : bank.ram_bank[1:0], bank.rom_bank[4:0]};
		case (info.mbc_kind)
			MBC_1:        bank_sel = {2'b00, mbc1_bank & info.rom_mask[6:0]};
			MBC_2, MBC_3: bank_sel = {2'b00, bank.rom_bank[6:0] & info.rom_mask[6:0]};
			MBC_5:        bank_sel = bank.rom_bank & info.rom_mask;
			default:      bank_sel = 9'd1; // plain rom, index ends up as bits 14..13
		endcase
	end

	assign rom_index = bus.addr[14] ? {bank_sel, bus.addr[13]} : {9'd0, bus.addr[13]};
	assign rom_addr  = dl_cart ? ROM_WORD_W'(dl_addr[22:1]) :
		ROM_WORD_W'({rom_index, bus.addr[12:1]});
	assign rom_we    = dl_cart & dl_wr; // download words go straight to rom

	// ----------------------------------------------------------
	// ram side
	// ----------------------------------------------------------
	always_comb begin
		case (info.mbc_kind)
			MBC_1:        ram_sel = bank.mbc1_mode ? (bank.ram_bank & info.ram_mask) : 4'd0;
			MBC_3, MBC_5: ram_sel = bank.ram_bank & info.ram_mask;
			default:      ram_sel = 4'd0;
		endcase
	end

	assign is_ram   = (bus.addr[15:13] == 3'b101); // 0xa000-0xbfff
	assign ram_addr = RAM_ADDR_W'({ram_sel, bus.addr[12:0]}); // wraps on small ram
	assign ram_we   = bus.wr & is_ram;

	// read source picked at the read cycle, ram byte joins one edge later
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q <= SEL_ZERO;
			nib_q <= 1'b0;
		end else if (bus.rd) begin
			nib_q <= (info.mbc_kind == MBC_2) && (bus.addr[15:9] == 7'b1010000);
			if (!info.cart_ready)    sel_q <= SEL_ZERO;
			else if (!is_ram)        sel_q <= SEL_ROM;
			else if (!bank.ram_enable) sel_q <= SEL_FF;
			else if (bank.rtc_mode && info.mbc_kind != MBC_2) sel_q <= SEL_ZERO;
			else                     sel_q <= SEL_RAM;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (bus.rd)
			rom_byte_q <= bus.addr[0] ? rom_q[15:8] : rom_q[7:0]; // odd byte on top
	end

	always_comb begin
		case (sel_q)
			SEL_FF:  cart_rdata = 8'hFF;
			SEL_ROM: cart_rdata = rom_byte_q;
			SEL_RAM: cart_rdata = nib_q ? {4'hF, ram_q[3:0]} : ram_q;
			default: cart_rdata = 8'h00;
		endcase
	end

endmodule

//--- src/cart_ram.sv
/*
 * cartridge ram
 * byte wide single port, write on the edge, registered read
 */
`timescale 1ns/100ps

module cart_ram import gb_cart_pkg::*; #(
	parameter int RAM_ADDR_W = 17 // 17 gives the full 128k
) (
	input  logic                  clk_sys,
	input  logic [RAM_ADDR_W-1:0] ram_addr,
	input  logic                  ram_we,
	input  byte_t                 ram_wdata,
	output byte_t                 ram_q
);

	localparam int DEPTH = 2 ** RAM_ADDR_W;

	byte_t mem [DEPTH]; // contents survive reset like battery ram

	// ----------------------------------------------------------
	// storage
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (ram_we)
			mem[ram_addr] <= ram_wdata;
		ram_q <= mem[ram_addr]; // old data on a same cycle write
	end

	// a write with a floating address would corrupt an unknown byte
	a_we_addr_known: assert property (@(posedge clk_sys)
		ram_we |-> !$isunknown(ram_addr))
		else $error("cart ram write with unknown address");

endmodule

//--- src/gb_cart_top.sv
/*
 * cartridge side of the handheld console core
 * header capture, bank controllers, address mapping and cart ram
 */
`timescale 1ns/100ps

module gb_cart_top import gb_cart_pkg::*; #(
	parameter int ROM_WORD_W = 22, // external rom word address width
	parameter int RAM_ADDR_W = 17  // cart ram byte address width
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  dl_cart,
	input  logic                  dl_wr,
	input  logic [22:0]           dl_addr,
	input  dl_word_t              dl_data,
	input  cart_addr_t            cart_addr,
	input  logic                  cart_rd,
	input  logic                  cart_wr,
	input  byte_t                 cart_wdata,
	output byte_t                 cart_rdata,
	output logic [ROM_WORD_W-1:0] rom_addr,
	output logic                  rom_we,
	output dl_word_t              rom_wdata,
	input  dl_word_t              rom_q
);

	cart_bus_if  bus ();
	cart_info_if info ();
	bank_if      bank ();

	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_we;
	byte_t                 ram_q;

	assign bus.addr  = cart_addr;
	assign bus.rd    = cart_rd;
	assign bus.wr    = cart_wr;
	assign bus.wdata = cart_wdata;
	assign rom_wdata = dl_data; // download words land in rom unchanged

	// ----------------------------------------------------------
	// submodules
	// ----------------------------------------------------------
	cart_header u_header (.clk_sys, .reset, .dl_cart, .dl_wr, .dl_addr, .dl_data, .info);

	mbc_regs u_regs (.clk_sys, .reset, .dl_cart, .bus, .info, .bank);

	cart_mapper #(.ROM_WORD_W(ROM_WORD_W), .RAM_ADDR_W(RAM_ADDR_W)) u_mapper (
		.clk_sys, .reset, .dl_cart, .dl_wr, .dl_addr, .bus, .info, .bank,
		.rom_q, .rom_addr, .rom_we, .ram_addr, .ram_we, .ram_q, .cart_rdata
	);

	cart_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram (
		.clk_sys, .ram_addr, .ram_we, .ram_wdata(cart_wdata), .ram_q
	);

endmodule

//--- tb/tb_gb_cart.sv
/*
 * testbench for the cartridge core
 * replays download, cpu write, cpu read and rom address cases from a
 * text file against a small rom model and checks every response
 */
`timescale 1ns/100ps

module tb_gb_cart;

	localparam string CASE_FILE  = "tb/gb_cart_cases.txt";
	localparam time   STEP_LIMIT = 400;    // ns allowed for one wait
	localparam int    RUN_LIMIT  = 200000; // ns for the whole run

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_cart;
	logic        dl_wr;
	logic [22:0] dl_addr;    // download byte address
	logic [15:0] dl_data;
	logic [15:0] cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_wdata;
	logic [7:0]  cart_rdata;
	logic [21:0] rom_addr;   // external rom word address
	logic        rom_we;
	logic [15:0] rom_wdata;
	logic [15:0] rom_q;

	int   checks      = 0;
	int   value_errs  = 0; // wrong values seen
	int   other_fails = 0; // timeouts and file trouble
	int   cases_run   = 0;
	logic stalled     = 1'b0;

	gb_cart_top dut (
		.clk_sys, .reset, .dl_cart, .dl_wr, .dl_addr, .dl_data,
		.cart_addr, .cart_rd, .cart_wr, .cart_wdata, .cart_rdata,
		.rom_addr, .rom_we, .rom_wdata, .rom_q
	);

	// rom model answers with the inverted low address byte on top
	assign rom_q = {~rom_addr[7:0], rom_addr[7:0]};

	initial begin
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	task automatic step_cycles(input int n);
		int  seen = 0;
		time t0;
		t0 = $time;
		while (seen < n && !stalled) begin
			@(negedge clk_sys);
			seen++;
			if ($time - t0 > STEP_LIMIT) begin
				stalled = 1'b1;
				other_fails++;
				$display("timeout: %0d clock cycles took longer than %0d ns", n, STEP_LIMIT);
			end
		end
	endtask

	task automatic check_value(input string name, input logic [23:0] exp_val,
			input logic [23:0] got);
		checks++;
		assert (got === exp_val) else begin
			value_errs++;
			$display("error %s: expected %h, got %h", name, exp_val, got);
		end
	endtask

	// every input is set together right after a falling edge
	task automatic set_inputs(input logic dl, input logic dlw, input logic rd,
			input logic wr, input logic [23:0] a, input logic [23:0] d);
		dl_cart    = dl;
		dl_wr      = dlw;
		dl_addr    = a[22:0];
		dl_data    = d[15:0];
		cart_addr  = a[15:0];
		cart_rd    = rd;
		cart_wr    = wr;
		cart_wdata = d[7:0];
	endtask

	task automatic run_case(input string op, input logic [23:0] a, input logic [23:0] d,
			input logic [23:0] exp_val, input string name);
		if (op == "D")
			set_inputs(1'b1, 1'b1, 1'b0, 1'b0, a, d); // one download word
		else if (op == "W")
			set_inputs(1'b0, 1'b0, 1'b0, 1'b1, a, d);
		else if (op == "R")
			set_inputs(1'b0, 1'b0, 1'b1, 1'b0, a, d);
		else if (op == "A")
			set_inputs(1'b0, 1'b0, 1'b0, 1'b0, a, d); // address only
		else begin
			set_inputs(1'b0, 1'b0, 1'b0, 1'b0, a, d);
			other_fails++;
			$display("case %s has an unknown operation %s", name, op);
		end
		#1; // combinational outputs settle in the low phase
		if (op == "D") begin
			check_value({name, "_we"}, 24'h1, {23'd0, rom_we});
			check_value({name, "_addr"}, exp_val, {2'd0, rom_addr});
			check_value({name, "_wdata"}, {8'd0, d[15:0]}, {8'd0, rom_wdata});
		end
		if (op == "A")
			check_value(name, exp_val, {2'd0, rom_addr});
		step_cycles(1);
		if (op == "R")
			check_value(name, exp_val, {16'd0, cart_rdata}); // one cycle latency
		cases_run++;
	endtask

	task automatic print_counts();
		$display("checks %0d, value errors %0d, other failures %0d",
			checks, value_errs, other_fails);
	endtask

	// ----------------------------------------------------------
	// case replay
	// ----------------------------------------------------------
	initial begin
		int          fd;
		int          n;
		string       line;
		string       op;
		string       name;
		logic [23:0] a;
		logic [23:0] d;
		logic [23:0] exp_val;

		reset = 1'b1;
		set_inputs(1'b0, 1'b0, 1'b0, 1'b0, 24'h0, 24'h0);
		step_cycles(8);
		reset = 1'b0;
		step_cycles(1);
		check_value("reset_rom_we", 24'h0, {23'd0, rom_we});
		check_value("reset_rdata", 24'h0, {16'd0, cart_rdata});

		fd = $fopen(CASE_FILE, "r");
		if (fd == 0) begin
			other_fails++;
			$display("could not open the case file %s", CASE_FILE);
		end else begin
			while (!$feof(fd) && !stalled) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin // skip blanks and comments
					n = $sscanf(line, "%s %h %h %h %s", op, a, d, exp_val, name);
					if (n == 5)
						run_case(op, a, d, exp_val, name);
					else begin
						other_fails++;
						$display("malformed line in the case file: %s", line);
					end
				end
			end
			$fclose(fd);
		end

		set_inputs(1'b0, 1'b0, 1'b0, 1'b0, 24'h0, 24'h0);
		step_cycles(2);
		if (cases_run == 0) begin
			other_fails++;
			$display("no cases were run from %s", CASE_FILE);
		end
		print_counts();
		if (value_errs == 0 && other_fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// overall run limit catches a stopped clock
	initial begin
		#(RUN_LIMIT);
		other_fails++;
		$display("timeout: the run did not finish within %0d ns", RUN_LIMIT);
		print_counts();
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tb/gb_cart_cases.txt
# op addr data expect name, all hex
# D download word (expect rom word addr), W cpu write, R cpu read (expect byte), A rom addr
R 0000 0000 000000 rd_before_dl
R 4000 0000 000000 rd_before_dl_bank
D 0146 0100 0000a3 mbc1_hdr_type
D 0148 0301 0000a4 mbc1_hdr_size
W 2000 0000 000000 mbc1_bank0_wr
A 4000 0000 002000 mbc1_bank0_is_1
W 2000 0005 000000 mbc1_bank5_wr
A 6002 0000 003001 mbc1_bank5_mirror
R 6002 0000 000001 mbc1_rd_lo
R 6003 0000 0000fe mbc1_rd_hi
R 0005 0000 0000fd mbc1_rd_fixed
D 0146 0100 0000a3 mbc1_2m_type
D 0148 0306 0000a4 mbc1_2m_size
W 2000 0003 000000 mbc1_2m_bank_wr
W 4000 0001 000000 mbc1_2m_ram_bank_wr
A 4000 0000 046000 mbc1_mode0_high
W 6000 0001 000000 mbc1_mode_wr
A 4000 0000 006000 mbc1_mode1_low
R 4007 0000 0000fc mbc1_mode1_rd
D 0146 1900 0000a3 mbc5_hdr_type
D 0148 0408 0000a4 mbc5_hdr_size
W 2000 0000 000000 mbc5_lo_wr
A 4000 0000 000000 mbc5_bank0
W 3000 0001 000000 mbc5_hi_wr
A 4000 0000 200000 mbc5_bank_100
W 2000 00a5 000000 mbc5_lo_a5_wr
A 6000 0000 34b000 mbc5_bank_1a5
R 6005 0000 0000fd mbc5_rd
R a000 0000 0000ff ram_disabled
W 0000 000a 000000 ram_enable_wr
W 4000 0002 000000 ram_bank2_sel
W a010 005a 000000 ram_bank2_wr
W 4000 0000 000000 ram_bank0_sel
W a010 00c3 000000 ram_bank0_wr
R a010 0000 0000c3 ram_bank0_rd
W 4000 0002 000000 ram_bank2_sel2
R a010 0000 00005a ram_bank2_rd
D 0146 1900 0000a3 ram32k_hdr_type
D 0148 0308 0000a4 ram32k_hdr_size
W 0000 000a 000000 ram32k_enable_wr
W 4000 0006 000000 ram32k_bank6_sel
R a010 0000 00005a ram32k_bank6_mirror
D 0146 0500 0000a3 mbc2_hdr_type
D 0148 0003 0000a4 mbc2_hdr_size
W 0000 000a 000000 mbc2_enable_wr
W a005 003c 000000 mbc2_ram_wr
R a005 0000 0000fc mbc2_nibble
D 0146 1300 0000a3 mbc3_hdr_type
D 0148 0305 0000a4 mbc3_hdr_size
W 0000 000a 000000 mbc3_enable_wr
W 4000 0001 000000 mbc3_bank1_sel
W a100 009e 000000 mbc3_ram_wr
W 4000 0008 000000 mbc3_rtc_sel
R a100 0000 000000 mbc3_rtc_rd
W 4000 0001 000000 mbc3_bank1_sel2
R a100 0000 00009e mbc3_ram_rd

//--- gb_cart.f
src/gb_cart_pkg.sv
src/gb_cart_ifs.sv
src/cart_header.sv
src/mbc_regs.sv
src/cart_mapper.sv
src/cart_ram.sv
src/gb_cart_top.sv
tb/tb_gb_cart.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_gb_cart
FILELIST  := gb_cart.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "result: pass" || (echo "result: fail"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
